/* project.f */
+incdir+common
common/pipeTypes_pkg.sv
common/busTypes_pkg.sv
common/dataBusIf.sv
src/memRequestBuilder.sv
src/loadAligner.sv
src/memStage.sv
dataRam/ramByteLane.sv
dataRam/dataRam.sv
src/memSubsystem.sv
tests/memSubsystem_asserts.sv
tests/memSubsystem_tb.sv

/* tests/memSubsystem_tb.sv */
`timescale 1ns/1ps
`include "memStage_cfg.svh"

module memSubsystem_tb;
    import pipeTypes_pkg::*;

    localparam int NUM_OPS = 300;
    localparam int FILL_WORDS = 16;
    localparam int WINDOW_BYTES = FILL_WORDS * 8;
    localparam int MAX_WAIT = `MEM_LATENCY + 6;
    localparam int OP_BUDGET = FILL_WORDS + 2 * NUM_OPS + 8;
    localparam int WATCHDOG_NS = OP_BUDGET * (`MEM_LATENCY + 6) * 10 + 1000;
    localparam logic [63:0] BASE_ADDR = 64'h0000_0000_0000_0100;
    localparam logic [63:0] MTVEC = 64'h0000_0000_8000_0040;
    localparam memMode_t LOAD_MODES [7] = '{LB, LH, LW, LD, LBU, LHU, LWU};
    localparam memMode_t STORE_MODES [4] = '{SB, SH, SW, SD};
    localparam memMode_t WIDE_MODES [8] = '{LH, LW, LD, LHU, LWU, SH, SW, SD};

    logic        clk = 1'b0;
    logic        rst;
    logic        inValid, isLoad, isStore, advance;
    logic [3:0]  memMode;
    logic [63:0] aluOut, storeData, instrAddr, mtvec;
    logic [4:0]  rd;
    logic        ready, outValid, writesBack, trapValid, jumpEn, fwdValid;
    logic [4:0]  outRd, fwdRd;
    logic [63:0] wbData, trapPc, jumpAddr, fwdData;
    logic [3:0]  trapCause;

    logic [31:0] rngState;
    logic [63:0] pcCounter;
    logic [7:0]  modelMem [WINDOW_BYTES];
    int          errorCount;

    memSubsystem DUT (
        .clk(clk), .rst(rst), .inValid(inValid), .isLoad(isLoad), .isStore(isStore),
        .memMode(memMode), .aluOut(aluOut), .storeData(storeData), .instrAddr(instrAddr),
        .mtvec(mtvec), .rd(rd), .advance(advance), .ready(ready), .outValid(outValid),
        .writesBack(writesBack), .trapValid(trapValid), .outRd(outRd), .wbData(wbData),
        .trapPc(trapPc), .jumpAddr(jumpAddr), .trapCause(trapCause), .jumpEn(jumpEn),
        .fwdValid(fwdValid), .fwdRd(fwdRd), .fwdData(fwdData)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic int accessBytes(memMode_t mode);
        case (mode)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default: return 8;
        endcase
    endfunction

    // little-endian gather from the model, then extend
    function automatic logic [63:0] predictLoad(int off, memMode_t mode);
        logic [63:0] raw;
        raw = '0;
        for (int k = 0; k < accessBytes(mode); k++) begin
            raw[8*k +: 8] = modelMem[off + k];
        end
        case (mode)
            LB: return {{56{raw[7]}}, raw[7:0]};
            LH: return {{48{raw[15]}}, raw[15:0]};
            LW: return {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    task automatic stopWithError(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            stopWithError($sformatf("MISMATCH %s actual=%h expected=%h",
                                    name, actual, expected));
        end
    endtask

    // present one op, wait for ready, advance it and check both sides
    task automatic runOp(input bit valid, input bit load, input bit store, input memMode_t mode,
                         input logic [63:0] value, input logic [63:0] data,
                         input logic [4:0] dest);
        logic [63:0] pc;
        logic [63:0] expData;
        bit          memOp;
        bit          trap;
        int          off;
        int          waitCycles;
        pc = pcCounter;
        pcCounter = pcCounter + 4;
        off = int'(value[6:0]);
        memOp = valid && (load || store);
        trap = memOp && (value % accessBytes(mode) != 0);
        expData = (memOp && load && !trap) ? predictLoad(off, mode) : value;
        inValid = valid;
        isLoad = load;
        isStore = store;
        memMode = mode;
        aluOut = value;
        storeData = data;
        rd = dest;
        instrAddr = pc;
        advance = 1'b0;
        waitCycles = 0;
        @(negedge clk);
        while (!ready) begin
            waitCycles++;
            if (waitCycles > MAX_WAIT) begin
                stopWithError("ready never rose after a memory access was presented");
            end
            @(negedge clk);
        end
        if (!memOp || trap) begin
            checkValue("readyDelay", 64'(waitCycles), 64'd0);
        end
        checkValue("jumpEn", jumpEn, trap);
        if (trap) begin
            checkValue("jumpAddr", jumpAddr, MTVEC);
        end
        checkValue("fwdValid", fwdValid, valid && dest != 0 && !store);
        if (valid && dest != 0 && !store && !trap) begin
            checkValue("fwdRd", fwdRd, dest);
            checkValue("fwdData", fwdData, expData);
        end
        advance = 1'b1;
        @(negedge clk);
        advance = 1'b0;
        inValid = 1'b0;
        checkValue("outValid", outValid, valid);
        checkValue("trapValid", trapValid, trap);
        checkValue("writesBack", writesBack, valid && !store && !trap);
        if (valid) begin
            checkValue("outRd", outRd, dest);
        end
        if (trap) begin
            checkValue("trapCause", trapCause, load ? 64'd4 : 64'd6);
            checkValue("trapPc", trapPc, pc);
        end else if (valid) begin
            checkValue("wbData", wbData, expData);
        end
        if (memOp && store && !trap) begin
            for (int k = 0; k < accessBytes(mode); k++) begin
                modelMem[off + k] = data[8*k +: 8];
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stopWithError("timeout, the test sequence did not finish in time");
    end

    initial begin
        int          kind;
        int          off;
        int          size;
        memMode_t    mode;
        logic [63:0] data;
        logic [4:0]  dest;
        rngState = 32'h56a6;
        errorCount = 0;
        pcCounter = 64'h0000_0000_8000_1000;
        rst = 1'b1;
        inValid = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        memMode = 4'd0;
        aluOut = '0;
        storeData = '0;
        instrAddr = '0;
        mtvec = MTVEC;
        rd = '0;
        advance = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue("outValid", outValid, 1'b0);
        checkValue("trapValid", trapValid, 1'b0);
        checkValue("jumpEn", jumpEn, 1'b0);
        // known contents for the whole window first
        for (int w = 0; w < FILL_WORDS; w++) begin
            runOp(1, 0, 1, SD, BASE_ADDR + 64'(8 * w), {nextRandom(), nextRandom()}, 5'd0);
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            kind = int'(nextRandom() % 8);
            data = {nextRandom(), nextRandom()};
            dest = 5'(nextRandom());
            off = int'(nextRandom() % WINDOW_BYTES);
            case (kind)
                0, 1: begin
                    mode = STORE_MODES[nextRandom() % 4];
                    off = off - (off % accessBytes(mode));
                    runOp(1, 0, 1, mode, BASE_ADDR + 64'(off), data, dest);
                end
                2, 3, 4: begin
                    mode = LOAD_MODES[nextRandom() % 7];
                    off = off - (off % accessBytes(mode));
                    runOp(1, 1, 0, mode, BASE_ADDR + 64'(off), data, dest);
                end
                5: begin
                    mode = WIDE_MODES[nextRandom() % 8];
                    size = accessBytes(mode);
                    off = off - (off % size) + 1 + int'(nextRandom() % (size - 1));
                    runOp(1, mode inside {LH, LW, LD, LHU, LWU}, mode inside {SH, SW, SD},
                          mode, BASE_ADDR + 64'(off), data, dest);
                    // memory must be untouched by the trap
                    runOp(1, 1, 0, LD, BASE_ADDR + 64'(off & ~7), '0, 5'd1);
                end
                6: runOp(1, 0, 0, memMode_t'(nextRandom() % 11), data, '0, dest);
                default: runOp(0, nextRandom() % 2, 0, LD, BASE_ADDR + 64'(off), data, dest);
            endcase
        end
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tests/memSubsystem_asserts.sv */
`timescale 1ns/1ps

module memSubsystem_asserts (
    input logic        clk,
    input logic        rst,
    input logic        reqValid,
    input logic [63:0] addr,
    input logic [1:0]  size,
    input logic [7:0]  strobe,
    input logic [63:0] wdata,
    input logic        respOk,
    input logic        ready,
    input logic        trap
);

    // request fields frozen until the memory answers
    holdRequest: assert property (@(posedge clk) disable iff (rst)
        reqValid && !respOk |=> reqValid && $stable(addr) && $stable(size)
            && $stable(strobe) && $stable(wdata))
        else $error("bus request dropped or changed before respOk");

    // a trapping access stays off the bus
    noTrapRequest: assert property (@(posedge clk) disable iff (rst)
        !reqValid && trap |=> !reqValid)
        else $error("bus request issued for a misaligned access");

    noEarlyReady: assert property (@(posedge clk) disable iff (rst)
        reqValid |-> !ready)
        else $error("ready high while a bus request is outstanding");

endmodule

bind memStage memSubsystem_asserts busChecks (
    .clk     (clk),
    .rst     (rst),
    .reqValid(bus.reqValid),
    .addr    (bus.addr),
    .size    (bus.size),
    .strobe  (bus.strobe),
    .wdata   (bus.wdata),
    .respOk  (bus.respOk),
    .ready   (ready),
    .trap    (trap)
);

/* src/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  logic              isLoad,
    input  logic              isStore,
    input  logic [3:0]        memMode,
    input  pipeTypes_pkg::u64 aluOut,
    input  pipeTypes_pkg::u64 storeData,
    input  pipeTypes_pkg::u64 instrAddr,
    input  pipeTypes_pkg::u64 mtvec,
    input  logic [4:0]        rd,
    input  logic              advance,
    output logic              ready,
    output logic              outValid,
    output logic              writesBack,
    output logic              trapValid,
    output logic [4:0]        outRd,
    output pipeTypes_pkg::u64 wbData,
    output pipeTypes_pkg::u64 trapPc,
    output pipeTypes_pkg::u64 jumpAddr,
    output logic [3:0]        trapCause,
    output logic              jumpEn,
    output logic              fwdValid,
    output logic [4:0]        fwdRd,
    output pipeTypes_pkg::u64 fwdData
);
    import pipeTypes_pkg::*;

    exMemReg_t stageIn;
    memWbReg_t stageOut;

    dataBusIf bus ();

    assign stageIn.valid = inValid;
    assign stageIn.isLoad = isLoad;
    assign stageIn.isStore = isStore;
    assign stageIn.memMode = memMode_t'(memMode);
    assign stageIn.aluOut = aluOut;
    assign stageIn.storeData = storeData;
    assign stageIn.rd = rd;
    assign stageIn.instrAddr = instrAddr;

    memStage stage (
        .clk     (clk),
        .rst     (rst),
        .stageIn (stageIn),
        .stageOut(stageOut),
        .ready   (ready),
        .advance (advance),
        .mtvec   (mtvec),
        .jumpEn  (jumpEn),
        .jumpAddr(jumpAddr),
        .fwdValid(fwdValid),
        .fwdRd   (fwdRd),
        .fwdData (fwdData),
        .bus     (bus.master)
    );

    dataRam ram (
        .clk(clk),
        .rst(rst),
        .bus(bus.slave)
    );

    // unpack the writeback record
    assign outValid = stageOut.valid;
    assign outRd = stageOut.rd;
    assign wbData = stageOut.wbData;
    assign writesBack = stageOut.writesBack;
    assign trapValid = stageOut.trapValid;
    assign trapCause = stageOut.trapCause;
    assign trapPc = stageOut.trapPc;

endmodule

/* dataRam/dataRam.sv */
`timescale 1ns/1ps
`include "memStage_cfg.svh"

module dataRam (
    input  logic     clk,
    input  logic     rst,
    dataBusIf.slave  bus
);
    import busTypes_pkg::*;

    localparam int LAT = `MEM_LATENCY;
    localparam int CW = $clog2(LAT + 1);
    localparam int IW = $clog2(`MEM_DEPTH_WORDS);

    logic          busy;
    logic          respQ;
    logic [CW-1:0] waitCnt;
    logic [IW-1:0] reqIdx;
    strobe_t       reqStrobe;
    logic [63:0]   reqData;

    // idle -> busy on a request, respOk after LAT cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            respQ <= 1'b0;
            waitCnt <= '0;
        end else if (!busy) begin
            if (bus.reqValid) begin
                busy <= 1'b1;
                waitCnt <= CW'(LAT - 1);
                respQ <= (LAT == 1);
            end
        end else if (respQ) begin
            busy <= 1'b0;
            respQ <= 1'b0;
        end else begin
            waitCnt <= waitCnt - 1'b1;
            respQ <= (waitCnt == CW'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && bus.reqValid) begin
            reqIdx <= bus.addr[3 +: IW];
            reqStrobe <= bus.strobe;
            reqData <= bus.wdata;
        end
    end

    assign bus.respOk = respQ;

    // one lane per byte, write lands at the end of the respOk cycle
    for (genvar i = 0; i < 8; i++) begin : gLane
        ramByteLane lane (
            .clk  (clk),
            .we   (respQ & reqStrobe[i]),
            .index(reqIdx),
            .wbyte(reqData[8*i +: 8]),
            .rbyte(bus.rdata[8*i +: 8])
        );
    end

endmodule

/* dataRam/ramByteLane.sv */
`timescale 1ns/1ps
`include "memStage_cfg.svh"

module ramByteLane (
    input  logic                                clk,
    input  logic                                we,
    input  logic [$clog2(`MEM_DEPTH_WORDS)-1:0] index,
    input  logic [7:0]                          wbyte,
    output logic [7:0]                          rbyte
);

    logic [7:0] mem [`MEM_DEPTH_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wbyte;
        end
    end

    // asynchronous read
    assign rbyte = mem[index];

endmodule

/* src/memStage.sv */
`timescale 1ns/1ps

module memStage (
    input  logic                    clk,
    input  logic                    rst,
    input  pipeTypes_pkg::exMemReg_t stageIn,
    output pipeTypes_pkg::memWbReg_t stageOut,
    output logic                    ready,
    input  logic                    advance,
    input  pipeTypes_pkg::u64       mtvec,
    output logic                    jumpEn,
    output pipeTypes_pkg::u64       jumpAddr,
    output logic                    fwdValid,
    output logic [4:0]              fwdRd,
    output pipeTypes_pkg::u64       fwdData,
    dataBusIf.master                bus
);
    import pipeTypes_pkg::*;
    import busTypes_pkg::*;

    u64         reqAddr;
    msize_t     reqSize;
    strobe_t    reqStrobe;
    u64         reqData;
    logic       misaligned;
    u64         memData;
    u64         loadData;
    u64         resultData;
    logic       started;
    logic       done;
    logic       isMem;
    logic       memOk;
    logic       trap;
    exception_t cause;

    memRequestBuilder reqBuilder (
        .addrReq   (stageIn.aluOut),
        .storeData (stageIn.storeData),
        .memMode   (stageIn.memMode),
        .addr      (reqAddr),
        .size      (reqSize),
        .strobe    (reqStrobe),
        .wdata     (reqData),
        .misaligned(misaligned)
    );

    loadAligner aligner (
        .addrReq (stageIn.aluOut),
        .memMode (stageIn.memMode),
        .rdata   (memData),
        .loadData(loadData)
    );

    assign isMem = stageIn.valid & (stageIn.isLoad | stageIn.isStore);
    assign memOk = isMem & ~misaligned;
    assign trap = isMem & misaligned;
    assign cause = !trap ? NO_EXCEPTION :
                   stageIn.isLoad ? LOAD_ADDRESS_MISALIGNED : STORE_ADDRESS_MISALIGNED;

    // stall until the bus answers, everything else leaves at once
    assign ready = ~memOk | done;

    assign jumpEn = trap;
    assign jumpAddr = mtvec;

    assign resultData = stageIn.isLoad ? loadData : stageIn.aluOut;
    assign fwdValid = stageIn.valid & (stageIn.rd != 5'd0) & ~stageIn.isStore;
    assign fwdRd = stageIn.rd;
    assign fwdData = resultData;

    // request and completion tracking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.reqValid <= 1'b0;
            started <= 1'b0;
            done <= 1'b0;
        end else begin
            if (memOk && !started) begin
                bus.reqValid <= 1'b1;
                started <= 1'b1;
            end
            if (bus.reqValid && bus.respOk) begin
                bus.reqValid <= 1'b0;
                done <= 1'b1;
            end
            // next instruction starts fresh
            if (advance) begin
                started <= 1'b0;
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memOk && !started) begin
            bus.addr <= reqAddr;
            bus.size <= reqSize;
            bus.strobe <= reqStrobe;
            bus.wdata <= reqData;
        end
        if (bus.reqValid && bus.respOk) begin
            memData <= bus.rdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageOut <= '0;
        end else if (advance) begin
            stageOut.valid <= stageIn.valid;
            stageOut.rd <= stageIn.rd;
            stageOut.wbData <= resultData;
            stageOut.writesBack <= stageIn.valid & ~stageIn.isStore & ~trap;
            stageOut.trapValid <= trap;
            stageOut.trapCause <= cause;
            stageOut.trapPc <= stageIn.instrAddr;
        end
    end

endmodule

/* src/loadAligner.sv */
`timescale 1ns/1ps

module loadAligner (
    input  pipeTypes_pkg::u64       addrReq,
    input  pipeTypes_pkg::memMode_t memMode,
    input  pipeTypes_pkg::u64       rdata,
    output pipeTypes_pkg::u64       loadData
);
    import pipeTypes_pkg::*;

    u64 shifted;

    // addressed byte lands in bits 7:0
    assign shifted = rdata >> {addrReq[2:0], 3'b000};

    always_comb begin
        case (memMode)
            LB:
                loadData = {{56{shifted[7]}}, shifted[7:0]};
            LH:
                loadData = {{48{shifted[15]}}, shifted[15:0]};
            LW:
                loadData = {{32{shifted[31]}}, shifted[31:0]};
            LBU:
                loadData = {56'b0, shifted[7:0]};
            LHU:
                loadData = {48'b0, shifted[15:0]};
            LWU:
                loadData = {32'b0, shifted[31:0]};
            // LD and the store modes take the full word
            default:
                loadData = rdata;
        endcase
    end

endmodule

/* src/memRequestBuilder.sv */
`timescale 1ns/1ps

module memRequestBuilder (
    input  pipeTypes_pkg::u64       addrReq,
    input  pipeTypes_pkg::u64       storeData,
    input  pipeTypes_pkg::memMode_t memMode,
    output pipeTypes_pkg::u64       addr,
    output busTypes_pkg::msize_t    size,
    output busTypes_pkg::strobe_t   strobe,
    output pipeTypes_pkg::u64       wdata,
    output logic                    misaligned
);
    import pipeTypes_pkg::*;
    import busTypes_pkg::*;

    logic [2:0] offset;
    logic [2:0] lowMask;
    strobe_t    byteMask;
    logic       isStoreMode;

    assign offset = addrReq[2:0];
    assign isStoreMode = memMode inside {SB, SH, SW, SD};

    // size, alignment mask and lane mask per access width
    always_comb begin
        size = MSIZE1;
        lowMask = 3'b000;
        byteMask = 8'h01;
        case (memMode)
            LH, LHU, SH: begin
                size = MSIZE2;
                lowMask = 3'b001;
                byteMask = 8'h03;
            end
            LW, LWU, SW: begin
                size = MSIZE4;
                lowMask = 3'b011;
                byteMask = 8'h0f;
            end
            LD, SD: begin
                size = MSIZE8;
                lowMask = 3'b111;
                byteMask = 8'hff;
            end
            default: ;
        endcase
    end

    assign addr = {addrReq[63:3], 3'b000};
    assign misaligned = |(offset & lowMask);
    assign strobe = isStoreMode ? strobe_t'(byteMask << offset) : '0;
    // store bytes moved up into their lanes
    assign wdata = storeData << {offset, 3'b000};

endmodule

/* common/dataBusIf.sv */
`timescale 1ns/1ps

interface dataBusIf;
    import busTypes_pkg::*;

    // request, held by the master until respOk
    logic        reqValid;
    logic [63:0] addr;
    msize_t      size;
    strobe_t     strobe;
    logic [63:0] wdata;

    // response, one cycle pulse
    logic        respOk;
    logic [63:0] rdata;

    modport master (
        output reqValid, addr, size, strobe, wdata,
        input  respOk, rdata
    );

    modport slave (
        input  reqValid, addr, size, strobe, wdata,
        output respOk, rdata
    );

endinterface

/* common/busTypes_pkg.sv */
package busTypes_pkg;

    // access size as log2 of the byte count
    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2,
        MSIZE8 = 2'd3
    } msize_t;

    // one bit per byte lane of the 64-bit word, all zero for a read
    typedef logic [7:0] strobe_t;

endpackage

/* common/pipeTypes_pkg.sv */
package pipeTypes_pkg;

    typedef logic [63:0] u64;

    // load and store access modes
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LD  = 4'd3,
        LBU = 4'd4,
        LHU = 4'd5,
        LWU = 4'd6,
        SB  = 4'd7,
        SH  = 4'd8,
        SW  = 4'd9,
        SD  = 4'd10
    } memMode_t;

    // machine cause codes, none uses a code outside the RISC-V table
    typedef enum logic [3:0] {
        NO_EXCEPTION             = 4'hf,
        LOAD_ADDRESS_MISALIGNED  = 4'd4,
        STORE_ADDRESS_MISALIGNED = 4'd6
    } exception_t;

    // from execute
    typedef struct packed {
        logic       valid;
        logic       isLoad;
        logic       isStore;
        memMode_t   memMode;
        u64         aluOut;
        u64         storeData;
        logic [4:0] rd;
        u64         instrAddr;
    } exMemReg_t;

    // toward writeback
    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        u64         wbData;
        logic       writesBack;
        logic       trapValid;
        exception_t trapCause;
        u64         trapPc;
    } memWbReg_t;

endpackage

/* common/memStage_cfg.svh */
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// number of 64-bit words held by the data memory
`define MEM_DEPTH_WORDS 256

// cycles from request acceptance to respOk, 1 or more
`define MEM_LATENCY 2

`endif
